//--- renderer_top.f
+incdir+.
render_pkg.sv
regmap_pkg.sv
render_regs.sv
tile_fetch.sv
ghost_sprite.sv
pixel_compose.sv
renderer_top.sv
tb_renderer.sv

//--- renderer_model.svh
`ifndef RENDERER_MODEL_SVH
`define RENDERER_MODEL_SVH

// register state as the host last wrote it
logic        m_power;
int          m_px;
int          m_py;
int          m_gx [`NUM_GHOSTS];
int          m_gy [`NUM_GHOSTS];
int          m_gdir [`NUM_GHOSTS];
logic [47:0] m_walls;
logic [47:0] m_dots;
logic [47:0] m_big;

// expected {r, g, b} of the pixels still in the pipeline, oldest first
logic [11:0] exp_q [$];

task automatic reset_model();
    m_power = 1'b0;
    m_px    = 0;
    m_py    = 0;
    m_walls = '0;
    m_dots  = '0;
    m_big   = '0;
    for (int i = 0; i < `NUM_GHOSTS; i++) begin
        m_gx[i]   = 0;
        m_gy[i]   = 0;
        m_gdir[i] = 0;
    end
endtask

// bit index inside the 8x8 box with its top-left corner at (bx, by), -1 when outside
function automatic int box_offset(input int x, input int y, input int bx, input int by);
    if (x < bx || x >= bx + `TILE_SIZE || y < by || y >= by + `TILE_SIZE)
        return -1;
    return (y - by) * `TILE_SIZE + (x - bx);
endfunction

function automatic logic [11:0] ghost_rgb(input int i, input int off);
    if (m_power) begin
        if (GHOST_FACE_MASK[off])
            return GHOST_FACE;
        return GHOST_BODY_MASK[off] ? GHOST_VOID : BG;
    end
    if (GHOST_EYE_MASK[m_gdir[i]][off])
        return GHOST_EYE;
    if (GHOST_SCLERA_MASK[m_gdir[i]][off])
        return GHOST_SCLERA;
    return GHOST_BODY_MASK[off] ? GHOST_BODY[i] : BG;
endfunction

function automatic logic [11:0] expected_rgb(input logic en, input int x, input int y);
    int   tile;
    int   off;
    int   row;
    int   col;
    logic on_map;
    if (!en)
        return 12'h000;
    on_map = (y < `SCREEN_H);
    tile   = (y / `TILE_SIZE) * `TILE_COLS + x / `TILE_SIZE;
    row    = y % `TILE_SIZE;
    col    = x % `TILE_SIZE;
    if (on_map && m_walls[tile])
        return WALL;
    off = box_offset(x, y, m_px, m_py);
    if (off >= 0)
        return PLAYER_MASK[off] ? PLAYER : BG;
    // ghost 0 first, so the lowest index wins
    for (int i = 0; i < `NUM_GHOSTS; i++) begin
        off = box_offset(x, y, m_gx[i], m_gy[i]);
        if (off >= 0)
            return ghost_rgb(i, off);
    end
    if (!on_map)
        return BG;
    if (m_big[tile])
        return DOT;
    if (m_dots[tile])
        return (row inside {3, 4} && col inside {3, 4}) ? DOT : BG;
    return BG;
endfunction

`endif

//--- tb_renderer.sv
`include "render_config.svh"
`default_nettype none

module tb_renderer;
    timeunit 1ns;
    timeprecision 1ns;

    import render_pkg::*;
    import regmap_pkg::*;

    // five full frames of 3072 pixels plus the APB traffic come to about 16000
    localparam int MAX_CYCLES = 20000;
    localparam logic [7:0] BAD_ADDR [5] = '{8'h18, 8'h1C, 8'h38, 8'hFC, 8'h05};

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    apb_word_u   pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        display_en;
    coord_t      pix_x;
    coord_t      pix_y;
    color_t      r;
    color_t      g;
    color_t      b;

    int    seed;
    int    errors;
    int    cycles;
    string cur_test;

    `include "renderer_model.svh"

    renderer_top renderer_top_inst (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .display_en(display_en), .pix_x(pix_x), .pix_y(pix_y),
        .r(r), .g(g), .b(b)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    // compare the pixel leaving the pipeline on each falling edge, then drive the next one
    task automatic tick(input logic en, input int x, input int y);
        logic [11:0] exp;
        @(negedge clk);
        if (exp_q.size() == 3) begin
            exp = exp_q.pop_front();
            check("rgb", exp, {r, g, b});
        end
        display_en = en;
        pix_x      = coord_t'(x);
        pix_y      = coord_t'(y);
        // a pixel taken in while reset is high stays black
        if (reset)
            exp_q.push_back(12'h000);
        else
            exp_q.push_back(expected_rgb(en, x, y));
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              input logic err, output logic [31:0] rdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        tick(1'b0, 0, 0);
        penable = 1'b1;
        tick(1'b0, 0, 0);
        rdata = prdata;
        check("pready", 32'h1, 32'(pready));
        check("pslverr", 32'(err), 32'(pslverr));
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    function automatic logic [31:0] sprite_word(input int idx);
        sprite_word_t w;
        w = '0;
        if (idx == 0) begin
            w.x = coord_t'(m_px);
            w.y = coord_t'(m_py);
        end else begin
            w.x   = coord_t'(m_gx[idx-1]);
            w.y   = coord_t'(m_gy[idx-1]);
            w.dir = dir_t'(m_gdir[idx-1]);
        end
        return w;
    endfunction

    task automatic write_ctrl(input logic pm);
        logic [31:0] rd;
        apb_access(1'b1, `REG_CTRL, {31'b0, pm}, 1'b0, rd);
        m_power = pm;
    endtask

    task automatic write_sprite(input int idx, input int x, input int y, input int d);
        sprite_word_t w;
        logic [31:0]  rd;
        w     = '0;
        w.x   = coord_t'(x);
        w.y   = coord_t'(y);
        w.dir = dir_t'(d);
        apb_access(1'b1, 8'(`REG_SPRITE_BASE + 4 * idx), w, 1'b0, rd);
        if (idx == 0) begin
            m_px = x % 64;
            m_py = y % 64;
        end else begin
            m_gx[idx-1]   = x % 64;
            m_gy[idx-1]   = y % 64;
            m_gdir[idx-1] = d % 4;
        end
    endtask

    task automatic write_row(input int row, input logic [7:0] w, input logic [7:0] d,
                             input logic [7:0] bd);
        tile_row_word_t t;
        logic [31:0]    rd;
        t          = '0;
        t.walls    = w;
        t.dots     = d;
        t.big_dots = bd;
        apb_access(1'b1, 8'(`REG_TILE_BASE + 4 * row), t, 1'b0, rd);
        m_walls[row*8 +: 8] = w;
        m_dots[row*8 +: 8]  = d;
        m_big[row*8 +: 8]   = bd;
    endtask

    task automatic verify_regs();
        tile_row_word_t t;
        logic [31:0]    rd;
        apb_access(1'b0, `REG_CTRL, '0, 1'b0, rd);
        check("ctrl readback", {31'b0, m_power}, rd);
        for (int i = 0; i < NUM_SPRITES; i++) begin
            apb_access(1'b0, 8'(`REG_SPRITE_BASE + 4 * i), '0, 1'b0, rd);
            check("sprite readback", sprite_word(i), rd);
        end
        for (int row = 0; row < `TILE_ROWS; row++) begin
            t          = '0;
            t.walls    = m_walls[row*8 +: 8];
            t.dots     = m_dots[row*8 +: 8];
            t.big_dots = m_big[row*8 +: 8];
            apb_access(1'b0, 8'(`REG_TILE_BASE + 4 * row), '0, 1'b0, rd);
            check("tile row readback", t, rd);
        end
    endtask

    // sparse thins the walls out so sprites stay visible
    task automatic random_tilemap(input logic sparse);
        logic [7:0] w;
        for (int row = 0; row < `TILE_ROWS; row++) begin
            w = 8'($random(seed));
            if (sparse)
                w = w & 8'($random(seed));
            write_row(row, w, 8'($random(seed)), 8'($random(seed)));
        end
    endtask

    task automatic scan_frame();
        for (int y = 0; y < `SCREEN_H; y++) begin
            for (int x = 0; x < `SCREEN_W; x++)
                tick(1'b1, x, y);
        end
        repeat (3) tick(1'b0, 0, 0);
    endtask

    initial begin
        logic [31:0] rd;
        int          x0;
        int          y0;
        seed       = 28976;
        errors     = 0;
        cur_test   = "reset";
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        display_en = 1'b0;
        pix_x      = '0;
        pix_y      = '0;
        reset_model();
        // live pixels over the player box while reset holds the pipeline
        repeat (9) tick(1'b1, rand_below(8), rand_below(8));
        tick(1'b0, 0, 0);
        reset = 1'b0;
        tick(1'b0, 0, 0);
        check("rgb after reset", 32'h0, {r, g, b});

        cur_test = "registers";
        write_ctrl(1'(rand_below(2)));
        for (int i = 0; i < NUM_SPRITES; i++)
            write_sprite(i, rand_below(64), rand_below(64), rand_below(4));
        random_tilemap(1'b0);
        verify_regs();
        foreach (BAD_ADDR[i]) begin
            apb_access(1'b1, BAD_ADDR[i], $random(seed), 1'b1, rd);
            apb_access(1'b0, BAD_ADDR[i], '0, 1'b1, rd);
        end
        verify_regs();
        write_ctrl(1'b0);

        cur_test = "tilemap";
        for (int i = 0; i < NUM_SPRITES; i++)
            write_sprite(i, 60, 44, i % 4);
        random_tilemap(1'b0);
        // tile under the parked sprites stays empty
        write_row(5, m_walls[47:40] & 8'h7F, m_dots[47:40] & 8'h7F, m_big[47:40] & 8'h7F);
        scan_frame();

        cur_test = "player";
        random_tilemap(1'b1);
        x0 = rand_below(57);
        y0 = rand_below(41);
        write_sprite(0, x0, y0, 0);
        write_sprite(1, x0 + 2, y0 + 3, rand_below(4));
        for (int i = 2; i < NUM_SPRITES; i++)
            write_sprite(i, rand_below(64), rand_below(48), rand_below(4));
        scan_frame();

        cur_test = "ghosts";
        write_sprite(0, 60, 44, 0);
        x0 = rand_below(57);
        y0 = rand_below(41);
        write_sprite(1, x0, y0, 0);
        write_sprite(2, x0 + 3, y0 + 2, 1);
        write_sprite(3, rand_below(64), rand_below(48), 2);
        write_sprite(4, rand_below(64), rand_below(48), 3);
        scan_frame();

        cur_test = "power";
        write_ctrl(1'b1);
        scan_frame();
        write_ctrl(1'b0);
        scan_frame();

        cur_test = "blanking";
        repeat (256) tick(1'b0, rand_below(64), rand_below(64));
        repeat (3) tick(1'b0, 0, 0);

        $display("tests reset registers tilemap player ghosts power blanking: %0d errors",
                 errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- renderer_top.sv
`include "render_config.svh"
`default_nettype none

module renderer_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  regmap_pkg::apb_word_u pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  display_en,
    input  render_pkg::coord_t    pix_x,
    input  render_pkg::coord_t    pix_y,
    output render_pkg::color_t    r,
    output render_pkg::color_t    g,
    output render_pkg::color_t    b
);
    import render_pkg::*;

    logic                  power_mode;
    coord_t                player_x;
    coord_t                player_y;
    coord_t                ghost_x [`NUM_GHOSTS];
    coord_t                ghost_y [`NUM_GHOSTS];
    dir_t                  ghost_dir [`NUM_GHOSTS];
    logic [47:0]           tile_walls;
    logic [47:0]           tile_dots;
    logic [47:0]           tile_big_dots;
    logic                  s1_en;
    coord_t                s1_x;
    coord_t                s1_y;
    tile_class_t           s1_class;
    logic [5:0]            s1_offset;
    logic [`NUM_GHOSTS-1:0] ghost_hit;
    color_t                ghost_r [`NUM_GHOSTS];
    color_t                ghost_g [`NUM_GHOSTS];
    color_t                ghost_b [`NUM_GHOSTS];

    render_regs render_regs_inst (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .power_mode(power_mode), .player_x(player_x),
        .player_y(player_y), .ghost_x(ghost_x), .ghost_y(ghost_y),
        .ghost_dir(ghost_dir), .tile_walls(tile_walls), .tile_dots(tile_dots),
        .tile_big_dots(tile_big_dots)
    );

    tile_fetch tile_fetch_inst (
        .clk(clk), .reset(reset), .display_en(display_en), .pix_x(pix_x),
        .pix_y(pix_y), .tile_walls(tile_walls), .tile_dots(tile_dots),
        .tile_big_dots(tile_big_dots), .s1_en(s1_en), .s1_x(s1_x), .s1_y(s1_y),
        .s1_class(s1_class), .s1_offset(s1_offset)
    );

    for (genvar i = 0; i < `NUM_GHOSTS; i++) begin : g_ghost
        ghost_sprite ghost_sprite_inst (
            .clk(clk), .reset(reset), .power_mode(power_mode),
            .s1_x(s1_x), .s1_y(s1_y),
            .ghost_x(ghost_x[i]), .ghost_y(ghost_y[i]), .ghost_dir(ghost_dir[i]),
            .body_r(GHOST_BODY[i][11:8]), .body_g(GHOST_BODY[i][7:4]),
            .body_b(GHOST_BODY[i][3:0]),
            .hit(ghost_hit[i]),
            .ghost_r(ghost_r[i]), .ghost_g(ghost_g[i]), .ghost_b(ghost_b[i])
        );
    end

    pixel_compose pixel_compose_inst (
        .clk(clk), .reset(reset), .s1_en(s1_en), .s1_x(s1_x), .s1_y(s1_y),
        .s1_class(s1_class), .s1_offset(s1_offset), .player_x(player_x),
        .player_y(player_y), .ghost_hit(ghost_hit), .ghost_r(ghost_r),
        .ghost_g(ghost_g), .ghost_b(ghost_b), .r(r), .g(g), .b(b)
    );

endmodule

`default_nettype wire

//--- pixel_compose.sv
`include "render_config.svh"
`default_nettype none

module pixel_compose (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    s1_en,
    input  render_pkg::coord_t      s1_x,
    input  render_pkg::coord_t      s1_y,
    input  render_pkg::tile_class_t s1_class,
    input  logic [5:0]              s1_offset,
    input  render_pkg::coord_t      player_x,
    input  render_pkg::coord_t      player_y,
    input  logic [`NUM_GHOSTS-1:0]  ghost_hit,
    input  render_pkg::color_t      ghost_r [`NUM_GHOSTS],
    input  render_pkg::color_t      ghost_g [`NUM_GHOSTS],
    input  render_pkg::color_t      ghost_b [`NUM_GHOSTS],
    output render_pkg::color_t      r,
    output render_pkg::color_t      g,
    output render_pkg::color_t      b
);
    import render_pkg::*;

    logic [`COORD_W:0] dx;
    logic [`COORD_W:0] dy;
    logic              player_in;
    logic              s2_en;
    tile_class_t       s2_class;
    logic [5:0]        s2_offset;
    logic              s2_player_hit;
    logic              s2_player_bit;
    logic              dot_bit;
    logic [11:0]       color;

    assign dx        = {1'b0, s1_x} - {1'b0, player_x};
    assign dy        = {1'b0, s1_y} - {1'b0, player_y};
    assign player_in = (dx[`COORD_W:3] == '0) && (dy[`COORD_W:3] == '0);

    // stage 2, kept level with the ghost units
    always_ff @(posedge clk) begin
        if (reset)
            s2_en <= 1'b0;
        else
            s2_en <= s1_en;
    end

    always_ff @(posedge clk) begin
        s2_class      <= s1_class;
        s2_offset     <= s1_offset;
        s2_player_hit <= player_in;
        s2_player_bit <= PLAYER_MASK[{dy[2:0], dx[2:0]}];
    end

    // small dot is the centre 2x2, rows and cols 3..4
    assign dot_bit = (s2_offset[5:3] inside {3'd3, 3'd4}) && (s2_offset[2:0] inside {3'd3, 3'd4});

    always_comb begin
        color = BG;
        if (s2_class == TILE_WALL) begin
            color = WALL;
        end else if (s2_player_hit) begin
            color = s2_player_bit ? PLAYER : BG;
        end else if (|ghost_hit) begin
            // walk downwards so ghost 0 wins an overlap
            for (int i = `NUM_GHOSTS - 1; i >= 0; i--) begin
                if (ghost_hit[i])
                    color = {ghost_r[i], ghost_g[i], ghost_b[i]};
            end
        end else if (s2_class == TILE_BIG_DOT) begin
            color = DOT;
        end else if (s2_class == TILE_DOT) begin
            color = dot_bit ? DOT : BG;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            {r, g, b} <= '0;
        else if (!s2_en)
            {r, g, b} <= '0;
        else
            {r, g, b} <= color;
    end

endmodule

`default_nettype wire

//--- ghost_sprite.sv
`include "render_config.svh"
`default_nettype none

module ghost_sprite (
    input  logic               clk,
    input  logic               reset,
    input  logic               power_mode,
    input  render_pkg::coord_t s1_x,
    input  render_pkg::coord_t s1_y,
    input  render_pkg::coord_t ghost_x,
    input  render_pkg::coord_t ghost_y,
    input  render_pkg::dir_t   ghost_dir,
    input  render_pkg::color_t body_r,
    input  render_pkg::color_t body_g,
    input  render_pkg::color_t body_b,
    output logic               hit,
    output render_pkg::color_t ghost_r,
    output render_pkg::color_t ghost_g,
    output render_pkg::color_t ghost_b
);
    import render_pkg::*;

    logic [`COORD_W:0] dx;
    logic [`COORD_W:0] dy;
    logic              in_box;
    logic [5:0]        offset;
    logic [11:0]       color;

    // one extra bit so a box near the edge does not wrap round
    assign dx     = {1'b0, s1_x} - {1'b0, ghost_x};
    assign dy     = {1'b0, s1_y} - {1'b0, ghost_y};
    assign in_box = (dx[`COORD_W:3] == '0) && (dy[`COORD_W:3] == '0);
    assign offset = {dy[2:0], dx[2:0]};

    always_comb begin
        color = BG;
        if (power_mode) begin
            if (GHOST_FACE_MASK[offset])
                color = GHOST_FACE;
            else if (GHOST_BODY_MASK[offset])
                color = GHOST_VOID;
        end else begin
            if (GHOST_EYE_MASK[ghost_dir][offset])
                color = GHOST_EYE;
            else if (GHOST_SCLERA_MASK[ghost_dir][offset])
                color = GHOST_SCLERA;
            else if (GHOST_BODY_MASK[offset])
                color = {body_r, body_g, body_b};
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            hit <= 1'b0;
        else
            hit <= in_box;
    end

    always_ff @(posedge clk) begin
        {ghost_r, ghost_g, ghost_b} <= color;
    end

endmodule

`default_nettype wire

//--- tile_fetch.sv
`include "render_config.svh"
`default_nettype none

module tile_fetch (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    display_en,
    input  render_pkg::coord_t      pix_x,
    input  render_pkg::coord_t      pix_y,
    input  logic [47:0]             tile_walls,
    input  logic [47:0]             tile_dots,
    input  logic [47:0]             tile_big_dots,
    output logic                    s1_en,
    output render_pkg::coord_t      s1_x,
    output render_pkg::coord_t      s1_y,
    output render_pkg::tile_class_t s1_class,
    output logic [5:0]              s1_offset
);
    import render_pkg::*;

    logic [5:0]  tile_idx;
    logic        on_map;
    tile_class_t tile_class;

    // 8 columns per row, so the index is just the two tile coordinates side by side
    assign tile_idx = {pix_y[5:3], pix_x[5:3]};
    assign on_map   = (pix_y < `SCREEN_H);

    always_comb begin
        tile_class = TILE_EMPTY;
        if (!on_map)
            tile_class = TILE_EMPTY;
        else if (tile_walls[tile_idx])
            tile_class = TILE_WALL;
        else if (tile_big_dots[tile_idx])
            tile_class = TILE_BIG_DOT;
        else if (tile_dots[tile_idx])
            tile_class = TILE_DOT;
    end

    always_ff @(posedge clk) begin
        if (reset)
            s1_en <= 1'b0;
        else
            s1_en <= display_en;
    end

    always_ff @(posedge clk) begin
        s1_x      <= pix_x;
        s1_y      <= pix_y;
        s1_class  <= tile_class;
        s1_offset <= {pix_y[2:0], pix_x[2:0]};
    end

endmodule

`default_nettype wire

//--- render_regs.sv
`include "render_config.svh"
`default_nettype none

module render_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  regmap_pkg::apb_word_u pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  power_mode,
    output render_pkg::coord_t    player_x,
    output render_pkg::coord_t    player_y,
    output render_pkg::coord_t    ghost_x [`NUM_GHOSTS],
    output render_pkg::coord_t    ghost_y [`NUM_GHOSTS],
    output render_pkg::dir_t      ghost_dir [`NUM_GHOSTS],
    output logic [47:0]           tile_walls,
    output logic [47:0]           tile_dots,
    output logic [47:0]           tile_big_dots
);
    import regmap_pkg::*;
    import render_pkg::*;

    logic [5:0] word_idx;
    logic [2:0] spr_sel;
    logic [2:0] row_sel;
    logic       is_ctrl;
    logic       is_sprite;
    logic       is_tile;
    logic       mapped;
    logic       access;
    apb_word_u  rd_word;

    assign word_idx  = paddr[7:2];
    assign spr_sel   = 3'(word_idx - SPRITE0);
    assign row_sel   = 3'(word_idx - TILE_ROW0);
    assign is_ctrl   = (paddr == `REG_CTRL);
    assign is_sprite = (paddr[1:0] == 2'b00) && (word_idx >= SPRITE0)
                       && (word_idx < SPRITE0 + NUM_SPRITES);
    assign is_tile   = (paddr[1:0] == 2'b00) && (word_idx >= TILE_ROW0)
                       && (word_idx < TILE_ROW0 + NUM_TILE_ROWS);
    assign mapped    = is_ctrl || is_sprite || is_tile;
    assign access    = psel && penable;

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

    always_ff @(posedge clk) begin
        if (reset) begin
            power_mode    <= 1'b0;
            player_x      <= '0;
            player_y      <= '0;
            tile_walls    <= '0;
            tile_dots     <= '0;
            tile_big_dots <= '0;
            for (int i = 0; i < `NUM_GHOSTS; i++) begin
                ghost_x[i]   <= '0;
                ghost_y[i]   <= '0;
                ghost_dir[i] <= DIR_RIGHT;
            end
        end else if (access && pwrite) begin
            if (is_ctrl) begin
                power_mode <= pwdata[0];
            end else if (is_sprite && spr_sel == 3'd0) begin
                player_x <= pwdata.sprite.x;
                player_y <= pwdata.sprite.y;
            end else if (is_sprite) begin
                ghost_x[spr_sel-1]   <= pwdata.sprite.x;
                ghost_y[spr_sel-1]   <= pwdata.sprite.y;
                ghost_dir[spr_sel-1] <= pwdata.sprite.dir;
            end else if (is_tile) begin
                tile_walls[row_sel*8 +: 8]    <= pwdata.tile_row.walls;
                tile_dots[row_sel*8 +: 8]     <= pwdata.tile_row.dots;
                tile_big_dots[row_sel*8 +: 8] <= pwdata.tile_row.big_dots;
            end
        end
    end

    // readback, player has no direction field
    always_comb begin
        rd_word = '0;
        if (is_ctrl) begin
            rd_word[0] = power_mode;
        end else if (is_sprite && spr_sel == 3'd0) begin
            rd_word.sprite.x = player_x;
            rd_word.sprite.y = player_y;
        end else if (is_sprite) begin
            rd_word.sprite.x   = ghost_x[spr_sel-1];
            rd_word.sprite.y   = ghost_y[spr_sel-1];
            rd_word.sprite.dir = ghost_dir[spr_sel-1];
        end else if (is_tile) begin
            rd_word.tile_row.walls    = tile_walls[row_sel*8 +: 8];
            rd_word.tile_row.dots     = tile_dots[row_sel*8 +: 8];
            rd_word.tile_row.big_dots = tile_big_dots[row_sel*8 +: 8];
        end
    end

    assign prdata = rd_word;

endmodule

`default_nettype wire

//--- regmap_pkg.sv
`include "render_config.svh"
`default_nettype none

package regmap_pkg;

    typedef struct packed {
        logic [17:0]      rsvd;
        render_pkg::dir_t   dir;
        render_pkg::coord_t y;
        render_pkg::coord_t x;
    } sprite_word_t;

    typedef struct packed {
        logic [7:0] rsvd;
        logic [7:0] big_dots;
        logic [7:0] dots;
        logic [7:0] walls;
    } tile_row_word_t;

    // the same APB word, decoded by address
    typedef union packed {
        sprite_word_t   sprite;
        tile_row_word_t tile_row;
    } apb_word_u;

    // word indices, paddr[7:2]
    localparam int CTRL          = `REG_CTRL >> 2;
    localparam int SPRITE0       = `REG_SPRITE_BASE >> 2;
    localparam int NUM_SPRITES   = `NUM_GHOSTS + 1;
    localparam int TILE_ROW0     = `REG_TILE_BASE >> 2;
    localparam int NUM_TILE_ROWS = `TILE_ROWS;

endpackage

`default_nettype wire

//--- render_pkg.sv
`include "render_config.svh"
`default_nettype none

package render_pkg;

    typedef logic [3:0] color_t;
    typedef logic [`COORD_W-1:0] coord_t;

    typedef enum logic [1:0] {
        DIR_RIGHT = 2'd0,
        DIR_LEFT  = 2'd1,
        DIR_UP    = 2'd2,
        DIR_DOWN  = 2'd3
    } dir_t;

    typedef enum logic [1:0] {
        TILE_EMPTY   = 2'd0,
        TILE_WALL    = 2'd1,
        TILE_DOT     = 2'd2,
        TILE_BIG_DOT = 2'd3
    } tile_class_t;

    // bit index is row * 8 + col, so each byte of the hex is one row, row 0 lowest
    typedef logic [`TILE_SIZE*`TILE_SIZE-1:0] sprite_mask_t;

    localparam sprite_mask_t PLAYER_MASK     = 64'h3C7E_1F07_071F_7E3C;
    localparam sprite_mask_t GHOST_BODY_MASK = 64'hDBFF_FFFF_FFFF_7E3C;
    localparam sprite_mask_t GHOST_FACE_MASK = 64'h0000_5A00_0024_0000;

    // pupils, indexed by dir_t
    localparam sprite_mask_t GHOST_EYE_MASK [4] = '{
        64'h0000_0000_4400_0000,
        64'h0000_0000_2200_0000,
        64'h0000_0000_0044_0000,
        64'h0000_0000_2200_0000
    };

    // whites of the eyes sit one row lower when looking down
    localparam sprite_mask_t GHOST_SCLERA_MASK [4] = '{
        64'h0000_0000_6666_0000,
        64'h0000_0000_6666_0000,
        64'h0000_0000_6666_0000,
        64'h0000_0066_6600_0000
    };

    // colour triples as {r, g, b}
    localparam logic [11:0] BG           = 12'h000;
    localparam logic [11:0] WALL         = 12'h22C;
    localparam logic [11:0] DOT          = 12'hFFF;
    localparam logic [11:0] PLAYER       = 12'hFF0;
    localparam logic [11:0] GHOST_BODY [`NUM_GHOSTS] = '{12'hF00, 12'hFBF, 12'h0FF, 12'hFB4};
    localparam logic [11:0] GHOST_VOID   = 12'h23F;
    localparam logic [11:0] GHOST_FACE   = 12'hFCA;
    localparam logic [11:0] GHOST_EYE    = 12'h00A;
    localparam logic [11:0] GHOST_SCLERA = 12'hFFF;

endpackage

`default_nettype wire

//--- render_config.svh
`ifndef RENDER_CONFIG_SVH
`define RENDER_CONFIG_SVH

// tile geometry
`define TILE_SIZE       8
`define TILE_COLS       8
`define TILE_ROWS       6

// screen is exactly the tilemap
`define SCREEN_W        64
`define SCREEN_H        48
`define COORD_W         6

`define NUM_GHOSTS      4

// APB byte offsets
`define REG_CTRL        8'h00
`define REG_SPRITE_BASE 8'h04
`define REG_TILE_BASE   8'h20

`endif
